// ==== enc_defs.svh ====
//--------------------------------------------------------------------
// widths and fixed phase timing of the nr ldpc encoder controller
// pulled in by the package and by the rtl blocks that need a number
//--------------------------------------------------------------------
`ifndef ENC_DEFS_SVH
`define ENC_DEFS_SVH

// word widths
`define ENC_ZC_W       9   // lifting size, up to 384
`define ENC_ROW_W      6   // base graph rows, up to 46
`define ENC_COL_W      5   // info columns, up to 22

// p2 covers the first core rows, p3 the rest
`define ENC_CORE_ROWS  4

// wait cycles after each phase
`define ENC_WR_DELAY   2   // accumulate write settle
`define ENC_MM_DELAY   6   // matrix multiply pipeline

`endif

// ==== enc_pkg.sv ====
//--------------------------------------------------------------------
// shared types of the encoder controller: counter words, engine
// strobe bundle and the phase encoding seen by every block
//--------------------------------------------------------------------
`default_nettype none

`include "enc_defs.svh"

package enc_pkg;

  typedef logic [`ENC_ZC_W-1:0]  hb_zc_t;   // lifting size / zc count
  typedef logic [`ENC_ROW_W-1:0] hb_row_t;  // base graph row
  typedef logic [`ENC_COL_W-1:0] hb_col_t;  // info column

  // per engine block framing
  typedef struct packed {
    logic sof;  // first word of frame
    logic sop;  // first word of block
    logic eop;  // last word of block
    logic eof;  // last word of frame or phase
  } strb_t;

  // each work phase is followed by its own pipeline wait
  typedef enum logic [3:0] {
    ph_wait,
    ph_init,          // latch frame parameters
    ph_data,          // info columns into accumulator
    ph_wait_data,
    ph_get_p1,        // accumulator read, p1 source
    ph_wait_get_p1,
    ph_do_p1,         // inverse psi multiply
    ph_wait_p1,
    ph_do_p2,         // core rows
    ph_wait_p2,
    ph_do_p3,         // extension rows
    ph_wait_p3,
    ph_done
  } phase_t;

endpackage

`default_nettype wire

// ==== enc_param_regs.sv ====
//--------------------------------------------------------------------
// frame parameter latch, holds the working lifting size, rows and
// columns and keeps their loop limits ready for the counters
//--------------------------------------------------------------------
`default_nettype none

`include "enc_defs.svh"

module enc_param_regs (
  input  logic             iclk,
  input  logic             ireset,
  input  enc_pkg::phase_t  state,
  input  enc_pkg::hb_zc_t  used_zc,
  input  enc_pkg::hb_row_t used_row,
  input  enc_pkg::hb_col_t used_col,
  output enc_pkg::hb_zc_t  zc_m1,
  output enc_pkg::hb_zc_t  zc_m2,
  output logic             zc_less2,
  output enc_pkg::hb_row_t row_m1,
  output enc_pkg::hb_row_t row_m2,
  output enc_pkg::hb_col_t col_m2
);

  logic load;

  // follows the inputs while idle, last load in init then frozen
  assign load = (state == enc_pkg::ph_wait) || (state == enc_pkg::ph_init);

  always_ff @(posedge iclk) begin
    if (load) begin
      zc_m1    <= used_zc - 1'b1;   // read block end
      zc_m2    <= used_zc - 2'd2;   // write block end, one early
      zc_less2 <= (used_zc < enc_pkg::hb_zc_t'(2));  // 1 word blocks
      row_m1   <= used_row - 1'b1;
      row_m2   <= used_row - 2'd2;  // lookahead for p3
      col_m2   <= used_col - 2'd2;
    end
  end

  // p2 always runs the full core, a shorter graph is illegal
  a_core_rows : assert property (@(posedge iclk) disable iff (ireset)
    (state == enc_pkg::ph_init) |-> (used_row >= enc_pkg::hb_row_t'(`ENC_CORE_ROWS)));

endmodule

`default_nettype wire

// ==== enc_phase_fsm.sv ====
//--------------------------------------------------------------------
// phase sequencer of the encoder controller, one frame per buffer
// handshake, with a shift register timing every post-phase wait
//--------------------------------------------------------------------
`default_nettype none

`include "enc_defs.svh"

module enc_phase_fsm (
  input  logic            iclk,
  input  logic            ireset,
  input  logic            buf_full,
  input  logic            obuf_empty,
  input  logic            inv_psi_zero,
  input  logic            zc_last,
  input  logic            col_last,
  input  logic            row_done,
  input  logic            row_last,
  output enc_pkg::phase_t state,
  output logic            mm_done
);

  logic [`ENC_MM_DELAY-2:0] delay;  // ones fill in from bit 0
  logic                     in_wait;
  logic                     wr_done;

  assign in_wait = state inside {enc_pkg::ph_wait_data, enc_pkg::ph_wait_get_p1,
                                 enc_pkg::ph_wait_p1, enc_pkg::ph_wait_p2,
                                 enc_pkg::ph_wait_p3};

  // tap n-2 gives exactly n wait cycles
  assign wr_done = delay[`ENC_WR_DELAY-2];
  assign mm_done = delay[`ENC_MM_DELAY-2];

  //--------------------------------------------------------------------
  // delay line
  //--------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      delay <= '0;
    end else if (in_wait) begin
      delay <= {delay[`ENC_MM_DELAY-3:0], 1'b1};
    end else begin
      delay <= '0;  // rearm for the next wait
    end
  end

  //--------------------------------------------------------------------
  // phase sequence
  //--------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= enc_pkg::ph_wait;
    end else begin
      case (state)
        enc_pkg::ph_wait : begin
          // full input and empty output, flags ignored otherwise
          if (buf_full && obuf_empty) state <= enc_pkg::ph_init;
        end
        enc_pkg::ph_init : state <= enc_pkg::ph_data;
        // upload, zc words per column
        enc_pkg::ph_data : begin
          if (zc_last && col_last) state <= enc_pkg::ph_wait_data;
        end
        enc_pkg::ph_wait_data : begin
          if (wr_done) state <= enc_pkg::ph_get_p1;
        end
        // single read block
        enc_pkg::ph_get_p1 : begin
          if (zc_last) state <= enc_pkg::ph_wait_get_p1;
        end
        enc_pkg::ph_wait_get_p1 : begin
          if (mm_done) state <= inv_psi_zero ? enc_pkg::ph_do_p2 : enc_pkg::ph_do_p1;
        end
        enc_pkg::ph_do_p1 : begin
          if (zc_last) state <= enc_pkg::ph_wait_p1;
        end
        enc_pkg::ph_wait_p1 : begin
          if (mm_done) state <= enc_pkg::ph_do_p2;
        end
        // core rows
        enc_pkg::ph_do_p2 : begin
          if (zc_last && row_done) state <= enc_pkg::ph_wait_p2;
        end
        enc_pkg::ph_wait_p2 : begin
          // graph with only core rows has no p3
          if (mm_done) state <= row_last ? enc_pkg::ph_done : enc_pkg::ph_do_p3;
        end
        enc_pkg::ph_do_p3 : begin
          if (zc_last && row_last) state <= enc_pkg::ph_wait_p3;
        end
        enc_pkg::ph_wait_p3 : begin
          if (mm_done) state <= enc_pkg::ph_done;
        end
        default : state <= enc_pkg::ph_wait;  // done, back to idle
      endcase
    end
  end

  // a frame starts only from idle with both buffers ready
  a_start_from_wait : assert property (@(posedge iclk) disable iff (ireset)
    (state == enc_pkg::ph_init) |->
      $past(state == enc_pkg::ph_wait && buf_full && obuf_empty));

endmodule

`default_nettype wire

// ==== enc_loop_counters.sv ====
//--------------------------------------------------------------------
// zc, column and row loop counters of the encoder controller with
// registered first/last flags, steered by the current phase
//--------------------------------------------------------------------
`default_nettype none

`include "enc_defs.svh"

module enc_loop_counters (
  input  logic             iclk,
  input  logic             ireset,
  input  enc_pkg::phase_t  state,
  input  enc_pkg::hb_zc_t  zc_m1,
  input  enc_pkg::hb_zc_t  zc_m2,
  input  logic             zc_less2,
  input  enc_pkg::hb_row_t row_m1,
  input  enc_pkg::hb_row_t row_m2,
  input  enc_pkg::hb_col_t col_m2,
  output enc_pkg::hb_zc_t  zc_cnt,
  output enc_pkg::hb_row_t row_cnt,
  output enc_pkg::hb_col_t col_cnt,
  output logic             zc_first,
  output logic             zc_second,
  output logic             zc_last,
  output logic             col_first,
  output logic             col_last,
  output logic             row_first,
  output logic             row_last,
  output logic             row_done
);

  localparam enc_pkg::hb_row_t p3_row0   = `ENC_CORE_ROWS;      // p3 entry row
  localparam enc_pkg::hb_row_t p2_row_pen = `ENC_CORE_ROWS - 2;  // one before last core

  logic zc_run;       // phase that steps zc
  logic zc_idle;      // post-phase wait
  logic zc_last_nxt;

  assign zc_run  = state inside {enc_pkg::ph_data, enc_pkg::ph_get_p1, enc_pkg::ph_do_p1,
                                 enc_pkg::ph_do_p2, enc_pkg::ph_do_p3};
  assign zc_idle = state inside {enc_pkg::ph_wait_data, enc_pkg::ph_wait_get_p1,
                                 enc_pkg::ph_wait_p1, enc_pkg::ph_wait_p2,
                                 enc_pkg::ph_wait_p3};

  // writes span zc words, reads zc+1 with the start cycle
  assign zc_last_nxt = (state == enc_pkg::ph_data) ? (zc_less2 | (zc_cnt == zc_m2))
                                                   : (zc_cnt == zc_m1);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      zc_cnt    <= '0;
      zc_first  <= 1'b0;
      zc_second <= 1'b0;
      zc_last   <= 1'b0;
      col_cnt   <= '0;
      col_first <= 1'b0;
      col_last  <= 1'b0;
      row_cnt   <= '0;
      row_first <= 1'b0;
      row_last  <= 1'b0;
      row_done  <= 1'b0;
    end else if (state == enc_pkg::ph_init) begin
      zc_cnt    <= '0;
      zc_first  <= 1'b1;
      zc_second <= 1'b0;
      zc_last   <= zc_less2;  // single word upload blocks
      col_cnt   <= '0;
      col_first <= 1'b1;
      col_last  <= 1'b0;
      row_cnt   <= '0;
      row_first <= 1'b1;
      row_last  <= 1'b0;
      row_done  <= 1'b0;
    end else begin
      //--------------------------------------------------------------------
      // zc loop
      //--------------------------------------------------------------------
      if (zc_run) begin
        zc_cnt    <= zc_last ? '0 : zc_cnt + 1'b1;
        zc_last   <= zc_last_nxt;
        zc_first  <= zc_last;
        zc_second <= zc_first;   // first valid of a read
      end else if (zc_idle) begin
        zc_cnt    <= '0;
        zc_first  <= 1'b1;
        zc_second <= 1'b0;
        zc_last   <= 1'b0;
      end

      // column loop, upload only
      if ((state == enc_pkg::ph_data) && zc_last) begin
        col_cnt   <= col_cnt + 1'b1;
        col_last  <= (col_cnt == col_m2);
        col_first <= col_last;
      end

      //--------------------------------------------------------------------
      // row loop
      //--------------------------------------------------------------------
      if (state == enc_pkg::ph_do_p2) begin
        row_last <= (row_cnt == row_m1);  // graph ends with the core
        if (zc_last) begin
          row_cnt   <= row_done ? p3_row0 : row_cnt + 1'b1;
          row_done  <= (row_cnt == p2_row_pen);
          row_first <= row_done;
        end
      end

      if (state == enc_pkg::ph_do_p3) begin
        // at a block end look at the row coming next
        row_last <= zc_last ? (row_cnt == row_m2) : (row_cnt == row_m1);
        if (zc_last) begin
          row_cnt   <= row_cnt + 1'b1;
          row_first <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== enc_strobe_gen.sv ====
//--------------------------------------------------------------------
// registered decode of phase and loop flags into the accumulate and
// multiply engine strobes, plus the end of frame buffer pulse
//--------------------------------------------------------------------
`default_nettype none

module enc_strobe_gen (
  input  logic             iclk,
  input  logic             ireset,
  input  enc_pkg::phase_t  state,
  input  logic             mm_done,
  input  logic             zc_first,
  input  logic             zc_second,
  input  logic             zc_last,
  input  logic             col_first,
  input  logic             col_last,
  input  logic             row_first,
  input  logic             row_last,
  input  logic             row_done,
  input  enc_pkg::hb_zc_t  zc_cnt,
  input  enc_pkg::hb_row_t row_cnt,
  input  enc_pkg::hb_col_t col_cnt,
  output logic             addr_clear,
  output logic             addr_enable,
  output logic             buf_rempty,
  output enc_pkg::hb_row_t hb_row,
  output logic             acu_write,
  output logic             acu_wstart,
  output enc_pkg::strb_t   acu_wstrb,
  output enc_pkg::hb_col_t acu_wcol,
  output logic             acu_read,
  output logic             acu_rstart,
  output logic             acu_rval,
  output enc_pkg::strb_t   acu_rstrb,
  output enc_pkg::hb_row_t acu_rrow,
  output logic             p1_read,
  output logic             p1_rstart,
  output logic             p1_rval,
  output enc_pkg::strb_t   p1_rstrb,
  output logic             p2_read,
  output logic             p2_rstart,
  output logic             p2_rval,
  output enc_pkg::strb_t   p2_rstrb,
  output enc_pkg::hb_row_t p2_rrow,
  output logic             p3_read,
  output logic             p3_rstart,
  output logic             p3_rval,
  output enc_pkg::strb_t   p3_rstrb
);

  logic st_data, st_get_p1, st_do_p1, st_do_p2, st_do_p3;
  logic rd_val;    // read block past its start cycle
  logic frm_end;   // last pipeline wait of the frame

  assign st_data   = (state == enc_pkg::ph_data);
  assign st_get_p1 = (state == enc_pkg::ph_get_p1);
  assign st_do_p1  = (state == enc_pkg::ph_do_p1);
  assign st_do_p2  = (state == enc_pkg::ph_do_p2);
  assign st_do_p3  = (state == enc_pkg::ph_do_p3);
  assign rd_val    = (zc_cnt != '0);
  assign frm_end   = mm_done & (((state == enc_pkg::ph_wait_p2) & row_last) |
                                (state == enc_pkg::ph_wait_p3));

  // handshake and valids, low out of reset
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      buf_rempty <= 1'b0;
      acu_write  <= 1'b0;
      acu_rval   <= 1'b0;
      p1_rval    <= 1'b0;
      p2_rval    <= 1'b0;
      p3_rval    <= 1'b0;
    end else begin
      buf_rempty <= frm_end;  // in release, out filled
      acu_write  <= st_data;
      acu_rval   <= st_get_p1 & rd_val;
      p1_rval    <= st_do_p1 & rd_val;
      p2_rval    <= st_do_p2 & rd_val;
      p3_rval    <= st_do_p3 & rd_val;
    end
  end

  always_ff @(posedge iclk) begin
    addr_clear  <= (state == enc_pkg::ph_init);
    addr_enable <= st_data;
    hb_row      <= row_cnt;
    //--------------------------------------------------------------------
    // accumulator write port
    //--------------------------------------------------------------------
    acu_wstart    <= st_data & zc_first;
    acu_wstrb.sof <= st_data & zc_first & col_first;
    acu_wstrb.sop <= st_data & zc_first;
    acu_wstrb.eop <= st_data & zc_last;
    acu_wstrb.eof <= st_data & zc_last & col_last;
    acu_wcol      <= col_cnt;
    //--------------------------------------------------------------------
    // read ports, start cycle carries no data
    //--------------------------------------------------------------------
    acu_read      <= st_get_p1 | st_do_p3;   // p3 also reads u
    acu_rstart    <= (st_get_p1 | st_do_p3) & zc_first;
    acu_rstrb.sof <= st_get_p1 & zc_second;
    acu_rstrb.sop <= st_get_p1 & zc_second;
    acu_rstrb.eop <= st_get_p1 & zc_last;
    acu_rstrb.eof <= st_get_p1 & zc_last;   // one block only
    acu_rrow      <= row_cnt;
    // p1 solve
    p1_read       <= st_do_p1;
    p1_rstart     <= st_do_p1 & zc_first;
    p1_rstrb.sof  <= st_do_p1 & zc_second & row_first;
    p1_rstrb.sop  <= st_do_p1 & zc_second;
    p1_rstrb.eop  <= st_do_p1 & zc_last;
    p1_rstrb.eof  <= 1'b0;   // no frame end on p1
    // p2, parity memory is also read for the p1 source and p3
    p2_read       <= st_get_p1 | st_do_p2 | st_do_p3;
    p2_rstart     <= (st_get_p1 | st_do_p2 | st_do_p3) & zc_first;
    p2_rstrb.sof  <= 1'b0;
    p2_rstrb.sop  <= st_do_p2 & zc_second;
    p2_rstrb.eop  <= st_do_p2 & zc_last;
    p2_rstrb.eof  <= st_do_p2 & zc_last & row_done;  // last core row
    p2_rrow       <= row_cnt;
    // p3 extension rows
    p3_read       <= st_do_p3;
    p3_rstart     <= st_do_p3 & zc_first;
    p3_rstrb.sof  <= 1'b0;
    p3_rstrb.sop  <= st_do_p3 & zc_second;
    p3_rstrb.eop  <= st_do_p3 & zc_last;
    p3_rstrb.eof  <= st_do_p3 & zc_last & row_last;
  end

  // engines share the data path, never two valids at once
  a_one_rval : assert property (@(posedge iclk) disable iff (ireset)
    $onehot0({acu_rval, p1_rval, p2_rval, p3_rval}));

endmodule

`default_nettype wire

// ==== enc_ctrl_top.sv ====
//--------------------------------------------------------------------
// nr ldpc encoder main controller, buffer handshake in, engine
// strobes and indexes out, one frame per full/empty pair
//--------------------------------------------------------------------
`default_nettype none

module enc_ctrl_top (
  input  logic             iclk,
  input  logic             ireset,
  input  logic             buf_full,
  input  logic             obuf_empty,
  input  logic             inv_psi_zero,
  input  enc_pkg::hb_zc_t  used_zc,
  input  enc_pkg::hb_row_t used_row,
  input  enc_pkg::hb_col_t used_col,
  output logic             addr_clear,
  output logic             addr_enable,
  output logic             buf_rempty,
  output enc_pkg::hb_row_t hb_row,
  output logic             acu_write,
  output logic             acu_wstart,
  output enc_pkg::strb_t   acu_wstrb,
  output enc_pkg::hb_col_t acu_wcol,
  output logic             acu_read,
  output logic             acu_rstart,
  output logic             acu_rval,
  output enc_pkg::strb_t   acu_rstrb,
  output enc_pkg::hb_row_t acu_rrow,
  output logic             p1_read,
  output logic             p1_rstart,
  output logic             p1_rval,
  output enc_pkg::strb_t   p1_rstrb,
  output logic             p2_read,
  output logic             p2_rstart,
  output logic             p2_rval,
  output enc_pkg::strb_t   p2_rstrb,
  output enc_pkg::hb_row_t p2_rrow,
  output logic             p3_read,
  output logic             p3_rstart,
  output logic             p3_rval,
  output enc_pkg::strb_t   p3_rstrb
);

  // phase and pipeline wait
  enc_pkg::phase_t  state;
  logic             mm_done;

  // latched limits
  enc_pkg::hb_zc_t  zc_m1;
  enc_pkg::hb_zc_t  zc_m2;
  logic             zc_less2;
  enc_pkg::hb_row_t row_m1;
  enc_pkg::hb_row_t row_m2;
  enc_pkg::hb_col_t col_m2;

  // loop state
  enc_pkg::hb_zc_t  zc_cnt;
  enc_pkg::hb_row_t row_cnt;
  enc_pkg::hb_col_t col_cnt;
  logic             zc_first;
  logic             zc_second;
  logic             zc_last;
  logic             col_first;
  logic             col_last;
  logic             row_first;
  logic             row_last;
  logic             row_done;

  // all block ports share the names above
  enc_param_regs    u_param_regs    (.*);
  enc_phase_fsm     u_phase_fsm     (.*);
  enc_loop_counters u_loop_counters (.*);
  enc_strobe_gen    u_strobe_gen    (.*);

endmodule

`default_nettype wire

// ==== tb_enc_checker.sv ====
//--------------------------------------------------------------------
// frame checker of the encoder controller testbench, tallies engine
// strobes between buffer handshakes and compares at each frame end
//--------------------------------------------------------------------
`default_nettype none

`include "enc_defs.svh"

module tb_enc_checker (
  input  logic             iclk,
  input  logic             ireset,
  input  logic             buf_full,
  input  logic             obuf_empty,
  input  logic             addr_clear,
  input  logic             addr_enable,
  input  logic             buf_rempty,
  input  enc_pkg::hb_row_t hb_row,
  input  logic             acu_write,
  input  logic             acu_wstart,
  input  enc_pkg::strb_t   acu_wstrb,
  input  enc_pkg::hb_col_t acu_wcol,
  input  logic             acu_read,
  input  logic             acu_rstart,
  input  logic             acu_rval,
  input  enc_pkg::strb_t   acu_rstrb,
  input  enc_pkg::hb_row_t acu_rrow,
  input  logic             p1_read,
  input  logic             p1_rstart,
  input  logic             p1_rval,
  input  enc_pkg::strb_t   p1_rstrb,
  input  logic             p2_read,
  input  logic             p2_rstart,
  input  logic             p2_rval,
  input  enc_pkg::strb_t   p2_rstrb,
  input  enc_pkg::hb_row_t p2_rrow,
  input  logic             p3_read,
  input  logic             p3_rstart,
  input  logic             p3_rval,
  input  enc_pkg::strb_t   p3_rstrb,
  input  int               frame_no,
  input  int               exp_zc,
  input  int               exp_rows,
  input  int               exp_cols,
  input  int               exp_wr,
  input  int               exp_p1,
  input  int               exp_p3,
  output int               errors,
  output int               frames
);

  int   wr, wsof, wsop, weop, weof;   // upload tallies
  int   clr, aen, wst;                // address and write start
  int   ar, asop, aeop;               // p1 source read
  int   ard, ars, asof, aeof;         // accumulator read port
  int   p1, p2, p2eof, p3, p3eof;
  int   p1rd, p1rs, p1sof, p1sop, p1eop, p1eof;
  int   p2rd, p2rs, p2sof, p2sop, p2eop;
  int   p3rd, p3rs, p3sof, p3sop, p3eop;
  int   frm_err;                      // mismatches in this frame
  logic armed;                        // both flags seen since last frame end
  logic rst_seen;

  task automatic compare(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: frame %0d %s is %0d, expected %0d",
               $time, frame_no, what, got, exp);
      frm_err++;
    end
  endtask

  task automatic clear_tallies();
    wr      = 0;
    wsof    = 0;
    wsop    = 0;
    weop    = 0;
    weof    = 0;
    clr     = 0;
    aen     = 0;
    wst     = 0;
    ar      = 0;
    asop    = 0;
    aeop    = 0;
    ard     = 0;
    ars     = 0;
    asof    = 0;
    aeof    = 0;
    p1      = 0;
    p2      = 0;
    p2eof   = 0;
    p3      = 0;
    p3eof   = 0;
    p1rd    = 0;
    p1rs    = 0;
    p1sof   = 0;
    p1sop   = 0;
    p1eop   = 0;
    p1eof   = 0;
    p2rd    = 0;
    p2rs    = 0;
    p2sof   = 0;
    p2sop   = 0;
    p2eop   = 0;
    p3rd    = 0;
    p3rs    = 0;
    p3sof   = 0;
    p3sop   = 0;
    p3eop   = 0;
    frm_err = 0;
  endtask

  //--------------------------------------------------------------------
  // frame end, all engines must be quiet by now
  //--------------------------------------------------------------------
  task automatic close_frame();
    int ext_rows;   // rows past the core
    int p1_on;      // p1 solve runs
    ext_rows = exp_rows - `ENC_CORE_ROWS;
    p1_on    = (exp_p1 != 0);
    if (acu_rval || p1_rval || p2_rval || p3_rval) begin
      $display("** Error at %0t: frame %0d valid still high at buf_rempty", $time, frame_no);
      frm_err++;
    end
    compare("addr_clear pulses", clr, 1);
    compare("addr_enable cycles", aen, exp_wr);
    compare("acu_write cycles", wr, exp_wr);
    compare("acu_wstart", wst, exp_cols);
    compare("upload sof", wsof, 1);
    compare("upload sop", wsop, exp_cols);   // one per column
    compare("upload eop", weop, exp_cols);
    compare("upload eof", weof, 1);
    compare("acu_rval cycles", ar, exp_zc);   // single block
    compare("acu read sof", asof, 1);
    compare("acu read sop", asop, 1);
    compare("acu read eop", aeop, 1);
    compare("acu read eof", aeof, 1);
    // p1 source block, then u again for every extension row
    compare("acu_read cycles", ard, (ext_rows + 1) * (exp_zc + 1));
    compare("acu_rstart", ars, ext_rows + 1);
    compare("p1_rval cycles", p1, exp_p1);
    compare("p1_read cycles", p1rd, p1_on * (exp_zc + 1));
    compare("p1_rstart", p1rs, p1_on);
    compare("p1 sof", p1sof, p1_on);
    compare("p1 sop", p1sop, p1_on);
    compare("p1 eop", p1eop, p1_on);
    compare("p1 eof", p1eof, 0);
    compare("p2_rval cycles", p2, `ENC_CORE_ROWS * exp_zc);
    // parity memory read for p1 source, core and extension rows
    compare("p2_read cycles", p2rd, (exp_rows + 1) * (exp_zc + 1));
    compare("p2_rstart", p2rs, exp_rows + 1);
    compare("p2 sof", p2sof, 0);
    compare("p2 sop", p2sop, `ENC_CORE_ROWS);
    compare("p2 eop", p2eop, `ENC_CORE_ROWS);
    compare("p2 eof", p2eof, 1);
    compare("p3_rval cycles", p3, exp_p3);
    compare("p3_read cycles", p3rd, ext_rows * (exp_zc + 1));
    compare("p3_rstart", p3rs, ext_rows);
    compare("p3 sof", p3sof, 0);
    compare("p3 sop", p3sop, ext_rows);
    compare("p3 eop", p3eop, ext_rows);
    compare("p3 eof", p3eof, (exp_p3 != 0));  // none without extension rows
    $display("frame %0d zc=%0d rows=%0d cols=%0d: %0d mismatches",
             frame_no, exp_zc, exp_rows, exp_cols, frm_err);
    errors += frm_err;
    frames++;
    armed = 1'b0;
    clear_tallies();
  endtask

  initial begin
    errors   = 0;
    frames   = 0;
    armed    = 1'b0;
    rst_seen = 1'b0;
    clear_tallies();
  end

  // sampled on the edge, outputs are the values of the cycle before
  always @(posedge iclk) begin
    if (ireset) begin
      if (rst_seen && (buf_rempty || acu_write || acu_rval || p1_rval ||
                       p2_rval || p3_rval)) begin
        $display("** Error at %0t: buf_rempty or a valid is high in reset", $time);
        errors++;
      end
      rst_seen = 1'b1;   // first edge only clears x
      armed    = 1'b0;
      clear_tallies();
    end else begin
      if (buf_full && obuf_empty) armed = 1'b1;
      clr += addr_clear;
      aen += addr_enable;
      wst += acu_wstart;
      if (acu_write) begin
        if (wr == 0 && !armed) begin
          $display("** Error at %0t: upload started before both buffer flags were high",
                   $time);
          frm_err++;
        end
        compare("acu_wcol", acu_wcol, wr / exp_zc);  // column of this word
        wr++;
      end
      wsof += acu_wstrb.sof;
      wsop += acu_wstrb.sop;
      weop += acu_wstrb.eop;
      weof += acu_wstrb.eof;
      ar   += acu_rval;
      asof += acu_rstrb.sof;
      asop += acu_rstrb.sop;
      aeop += acu_rstrb.eop;
      aeof += acu_rstrb.eof;
      ard  += acu_read;
      ars  += acu_rstart;
      p1   += p1_rval;
      p1rd  += p1_read;
      p1rs  += p1_rstart;
      p1sof += p1_rstrb.sof;
      p1sop += p1_rstrb.sop;
      p1eop += p1_rstrb.eop;
      p1eof += p1_rstrb.eof;
      if (p2_rval) begin
        compare("p2_rrow", p2_rrow, p2 / exp_zc);  // core row 0 to 3
        compare("p2 hb_row", hb_row, p2 / exp_zc);
        p2++;
      end
      p2rd  += p2_read;
      p2rs  += p2_rstart;
      p2sof += p2_rstrb.sof;
      p2sop += p2_rstrb.sop;
      p2eop += p2_rstrb.eop;
      p2eof += p2_rstrb.eof;
      if (p3_rval) begin
        // extension rows follow the core
        compare("p3 hb_row", hb_row, `ENC_CORE_ROWS + p3 / exp_zc);
        compare("acu_rrow", acu_rrow, `ENC_CORE_ROWS + p3 / exp_zc);
        p3++;
      end
      p3rd  += p3_read;
      p3rs  += p3_rstart;
      p3sof += p3_rstrb.sof;
      p3sop += p3_rstrb.sop;
      p3eop += p3_rstrb.eop;
      p3eof += p3_rstrb.eof;
      if (buf_rempty) close_frame();
    end
  end

endmodule

`default_nettype wire

// ==== tb_enc_ctrl.sv ====
//--------------------------------------------------------------------
// testbench of the encoder controller, runs a table of frames through
// the buffer handshake and leaves the comparing to the checker
//--------------------------------------------------------------------
`default_nettype none

module tb_enc_ctrl;

  localparam int period     = 8;
  localparam int rst_cycles = 16;
  localparam int n_frames   = 8;

  logic             iclk;
  logic             ireset;
  logic             buf_full;
  logic             obuf_empty;
  logic             inv_psi_zero;
  enc_pkg::hb_zc_t  used_zc;
  enc_pkg::hb_row_t used_row;
  enc_pkg::hb_col_t used_col;
  logic             addr_clear;
  logic             addr_enable;
  logic             buf_rempty;
  enc_pkg::hb_row_t hb_row;
  logic             acu_write;
  logic             acu_wstart;
  enc_pkg::strb_t   acu_wstrb;
  enc_pkg::hb_col_t acu_wcol;
  logic             acu_read;
  logic             acu_rstart;
  logic             acu_rval;
  enc_pkg::strb_t   acu_rstrb;
  enc_pkg::hb_row_t acu_rrow;
  logic             p1_read;
  logic             p1_rstart;
  logic             p1_rval;
  enc_pkg::strb_t   p1_rstrb;
  logic             p2_read;
  logic             p2_rstart;
  logic             p2_rval;
  enc_pkg::strb_t   p2_rstrb;
  enc_pkg::hb_row_t p2_rrow;
  logic             p3_read;
  logic             p3_rstart;
  logic             p3_rval;
  enc_pkg::strb_t   p3_rstrb;
  int               frame_no, exp_zc, exp_rows, exp_cols;
  int               exp_wr, exp_p1, exp_p3;
  int               errors, frames;

  // zc, rows, cols, inv_psi_zero | upload, p1 solve, p3 valid cycles
  int frame_tab [n_frames][7] = '{
    '{ 4,  6,  3, 0,  12,  4,    8},
    '{ 1,  5,  2, 0,   2,  1,    1},
    '{ 2,  4,  4, 1,   8,  0,    0},   // core rows only
    '{ 8,  4,  2, 0,  16,  8,    0},
    '{16,  9, 10, 1, 160,  0,   80},
    '{ 3,  7, 22, 0,  66,  3,    9},
    '{ 1,  4,  2, 1,   2,  0,    0},
    '{32, 46, 22, 0, 704, 32, 1344}    // full size graph
  };

  enc_ctrl_top u_enc_ctrl_top (
    .iclk, .ireset, .buf_full, .obuf_empty, .inv_psi_zero,
    .used_zc, .used_row, .used_col,
    .addr_clear, .addr_enable, .buf_rempty, .hb_row,
    .acu_write, .acu_wstart, .acu_wstrb, .acu_wcol,
    .acu_read, .acu_rstart, .acu_rval, .acu_rstrb, .acu_rrow,
    .p1_read, .p1_rstart, .p1_rval, .p1_rstrb,
    .p2_read, .p2_rstart, .p2_rval, .p2_rstrb, .p2_rrow,
    .p3_read, .p3_rstart, .p3_rval, .p3_rstrb
  );

  tb_enc_checker u_checker (.*);

  initial begin
    iclk = 1'b0;
    forever #(period / 2) iclk = ~iclk;
  end

  // inputs move just after the edge
  task automatic step();
    @(posedge iclk);
    #1;
  endtask

  task automatic load_frame(input int f);
    frame_no     = f;
    used_zc      = enc_pkg::hb_zc_t'(frame_tab[f][0]);
    used_row     = enc_pkg::hb_row_t'(frame_tab[f][1]);
    used_col     = enc_pkg::hb_col_t'(frame_tab[f][2]);
    inv_psi_zero = (frame_tab[f][3] != 0);
    exp_zc       = frame_tab[f][0];
    exp_rows     = frame_tab[f][1];
    exp_cols     = frame_tab[f][2];
    exp_wr       = frame_tab[f][4];
    exp_p1       = frame_tab[f][5];
    exp_p3       = frame_tab[f][6];
  endtask

  task automatic wait_done();
    do begin
      step();
    end while (!buf_rempty);
  endtask

  //--------------------------------------------------------------------
  // frame sequence
  //--------------------------------------------------------------------
  initial begin
    void'($urandom(32'hdbb9));
    ireset     = 1'b1;
    buf_full   = 1'b0;
    obuf_empty = 1'b0;
    load_frame(0);
    repeat (rst_cycles) @(posedge iclk);
    #1;
    ireset = 1'b0;
    for (int f = 0; f < n_frames; f++) begin
      load_frame(f);
      repeat ($urandom_range(7)) step();  // producer side first
      buf_full = 1'b1;
      repeat ($urandom_range(7)) step();
      obuf_empty = 1'b1;
      wait_done();
      buf_full   = 1'b0;  // drop before fsm is back in wait
      obuf_empty = 1'b0;
      step();             // checker closes the frame here
    end
    repeat (4) step();
    $display("frames checked %0d of %0d, mismatches %0d", frames, n_frames, errors);
    if (errors == 0 && frames == n_frames) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog, twice the nominal length of the whole table
  initial begin
    int limit;
    limit = 0;
    for (int f = 0; f < n_frames; f++) begin
      limit += frame_tab[f][0] * (frame_tab[f][2] + frame_tab[f][1] + 2) + 40;
    end
    limit = 2 * limit + rst_cycles;
    repeat (limit) @(posedge iclk);
    $display("timeout after %0d cycles, frame %0d never reached its done pulse",
             limit, frame_no);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
enc_pkg.sv
enc_param_regs.sv
enc_phase_fsm.sv
enc_loop_counters.sv
enc_strobe_gen.sv
enc_ctrl_top.sv
tb_enc_checker.sv
tb_enc_ctrl.sv
